/* testdata.txt */
// Six hex digits per line: 1 for write or 0 for read, then the leaf,
// then four digits of the address of the last beat on the path; ffffff ends the list
0000b8
070160
130100
050130
1200e8
160148
0100d0
140118
040118
170160
1000b8
030100
ffffff

/* list.f */
oramPkg.sv
backendControl.sv
dramInitializer.sv
pathAddrGen.sv
pathORAMBackend.sv
backend_properties.sv
tbChecker.sv
tbBackend.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbBackend -f list.f
output=$(./obj_dir/VtbBackend +verilator+error+limit+1000)
echo "$output"
echo "$output" | grep -qx "No errors"

/* tbBackend.sv */
// --------------------------------------------------------------------------
// Testbench top, clock, reset, data file stimulus and final report
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tbBackend import oramPkg::*; ();

	logic Clock;
	logic rstN;
	logic CommandValid;
	logic Command;
	logic [ORAML-1:0] CurrentLeaf;
	logic CommandReady;
	logic [DDRAWidth-1:0] DRAMCommandAddress;
	logic [DDRCWidth-1:0] DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	logic [DDRDWidth-1:0] DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;
	logic [DDRAWidth-1:0] expectedLast;
	int errorCount;
	int testsPassed;
	int testsFailed;
	// Each entry is write flag, leaf and last path address
	logic [23:0] vectors [0:31];
	logic [7:0] lfsr;
	logic timedOut;
	int tbErrors;
	int sent;
	int totalErrors;

	pathORAMBackend dut_i (
		.Clock(Clock),
		.rstN(rstN),
		.CommandValid(CommandValid),
		.Command(Command),
		.CurrentLeaf(CurrentLeaf),
		.CommandReady(CommandReady),
		.DRAMCommandAddress(DRAMCommandAddress),
		.DRAMCommand(DRAMCommand),
		.DRAMCommandValid(DRAMCommandValid),
		.DRAMCommandReady(DRAMCommandReady),
		.DRAMWriteData(DRAMWriteData),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(DRAMWriteDataReady)
	);

	tbChecker checker_i (
		.Clock(Clock),
		.rstN(rstN),
		.CommandValid(CommandValid),
		.Command(Command),
		.CurrentLeaf(CurrentLeaf),
		.CommandReady(CommandReady),
		.expectedLast(expectedLast),
		.DRAMCommandAddress(DRAMCommandAddress),
		.DRAMCommand(DRAMCommand),
		.DRAMCommandValid(DRAMCommandValid),
		.DRAMCommandReady(DRAMCommandReady),
		.DRAMWriteData(DRAMWriteData),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(DRAMWriteDataReady),
		.errorCount(errorCount),
		.testsPassed(testsPassed),
		.testsFailed(testsFailed)
	);

	// 10 ns period
	always #5 Clock = ~Clock;

	// 8-bit Fibonacci LFSR, taps 8 6 5 4
	function automatic logic [7:0] lfsrStep(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	// Random back-pressure, one fresh bit per ready
	always @(negedge Clock) begin
		lfsr = lfsrStep(lfsr);
		DRAMCommandReady = lfsr[0];
		lfsr = lfsrStep(lfsr);
		DRAMWriteDataReady = lfsr[0];
	end

	// CommandReady only moves on rising edges, so falling edges see it settled
	task automatic waitCommandReady(input int limit, input string what);
		int cycles;
		cycles = 0;
		while (!CommandReady && cycles < limit) begin
			@(negedge Clock);
			cycles++;
		end
		if (!CommandReady) begin
			$display("Timeout after %0d cycles waiting for %s", limit, what);
			tbErrors++;
			timedOut = 1'b1;
		end
	endtask

	// Ready is already high here, transfer on the coming rising edge
	task automatic sendCommand(input logic [23:0] entry);
		CommandValid = 1'b1;
		Command = entry[20];
		CurrentLeaf = entry[16 +: ORAML];
		expectedLast = entry[15:0];
		@(negedge Clock);
		CommandValid = 1'b0;
	endtask

	initial begin
		Clock = 1'b0;
		rstN = 1'b0;
		CommandValid = 1'b0;
		Command = 1'b0;
		CurrentLeaf = '0;
		expectedLast = '0;
		DRAMCommandReady = 1'b0;
		DRAMWriteDataReady = 1'b0;
		lfsr = 8'd59;
		timedOut = 1'b0;
		tbErrors = 0;
		sent = 0;
		$readmemh("testdata.txt", vectors);
		// Reset over three rising edges
		repeat (3) @(negedge Clock);
		rstN = 1'b1;
		waitCommandReady(2000, "end of initialization");
		// List ends at the all-ones entry
		while (!timedOut && sent < $size(vectors) && vectors[sent] !== 24'hffffff
			&& !$isunknown(vectors[sent])) begin
			sendCommand(vectors[sent]);
			sent++;
			waitCommandReady(200, "end of path");
		end
		@(negedge Clock);
		if (!timedOut && sent == 0) begin
			$display("No commands were read from testdata.txt");
			tbErrors++;
		end
		if (!timedOut && testsPassed + testsFailed != sent + 1) begin
			$display("Finished tests do not match the %0d commands sent", sent);
			tbErrors++;
		end
		totalErrors = errorCount + tbErrors + dut_i.props_i.failCount;
		$display("Tests passed %0d, failed %0d, total errors %0d",
			testsPassed, testsFailed, totalErrors);
		if (totalErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* tbChecker.sv */
// --------------------------------------------------------------------------
// Testbench checker, follows every DRAM and frontend transfer
// Expected addresses and data come from the tree layout rules
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tbChecker import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	// Frontend channel
	input logic CommandValid,
	input logic Command,
	input logic [ORAML-1:0] CurrentLeaf,
	input logic CommandReady,
	// Last path address from the data file
	input logic [DDRAWidth-1:0] expectedLast,
	// DRAM channels
	input logic [DDRAWidth-1:0] DRAMCommandAddress,
	input logic [DDRCWidth-1:0] DRAMCommand,
	input logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [DDRDWidth-1:0] DRAMWriteData,
	input logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady,
	output int errorCount,
	output int testsPassed,
	output int testsFailed
);

	// Init walk progress, commands and data counted apart
	int initCmds;
	int initData;
	logic initFinished;
	// Current path
	logic pathActive;
	int pathBeats;
	int pathNumber;
	int pathStartErrors;
	int pathLeaf;
	logic pathWrite;
	logic [DDRAWidth-1:0] pathLast;
	logic [DDRAWidth-1:0] expAddr;
	logic [DDRCWidth-1:0] expCmd;
	dramWord word;

	initial begin
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		initCmds = 0;
		initData = 0;
		initFinished = 1'b0;
		pathActive = 1'b0;
		pathNumber = 0;
	end

	// ----------------------------------------------------------------------
	// Reference rules
	// ----------------------------------------------------------------------

	// Beat n of the init walk is beat n mod 3 of bucket n / 3
	function automatic logic [DDRAWidth-1:0] initAddress(input int n);
		int bucket;
		int beat;
		bucket = n / BucketBeats;
		beat = n % BucketBeats;
		return DDRAWidth'((bucket * BucketBeats + beat) * BeatStride);
	endfunction

	// Heap index of the ancestor of a leaf at one level, root is 0
	function automatic int pathBucket(input int leaf, input int level);
		return ((leaf + (1 << ORAML)) >> (ORAML - level)) - 1;
	endfunction

	// Path beat n, levels from root down, three beats each
	function automatic logic [DDRAWidth-1:0] pathAddress(input int leaf, input int n);
		int level;
		int beat;
		level = n / BucketBeats;
		beat = n % BucketBeats;
		return DDRAWidth'((pathBucket(leaf, level) * BucketBeats + beat) * BeatStride);
	endfunction

	// ----------------------------------------------------------------------
	// Reporting
	// ----------------------------------------------------------------------

	task automatic mismatch(input string msg);
		errorCount++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic failure(input string msg);
		errorCount++;
		$display("%s, at time %0t", msg, $time);
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errorCount == startErrors) begin
			testsPassed++;
			$display("Test %s: passed", name);
		end else begin
			testsFailed++;
			$display("Test %s: failed", name);
		end
	endtask

	// ----------------------------------------------------------------------
	// Transfer monitor
	// ----------------------------------------------------------------------

	always @(posedge Clock) begin
		if (rstN) begin
			if (CommandReady && !initFinished) begin
				failure("CommandReady went high before initialization finished");
			end
			// Write data, header on beat 0 and zero otherwise
			if (DRAMWriteDataValid && (initFinished || initData >= NumBeats)) begin
				failure("Write data valid outside initialization");
			end else if (DRAMWriteDataValid && DRAMWriteDataReady) begin
				word.raw = DRAMWriteData;
				if (initData % BucketBeats == 0) begin
					if (word.header.valid != '0 || word.header.pad != '0
						|| word.header.iv != IVWidth'(initData / BucketBeats)) begin
						mismatch($sformatf("header of bucket %0d is %h",
							initData / BucketBeats, word.raw));
					end
				end else if (word.raw != '0) begin
					mismatch($sformatf("init beat %0d data %h, expected zero", initData, word.raw));
				end
				initData++;
			end
			// Commands, init walk first, then path beats
			if (DRAMCommandValid && DRAMCommandReady) begin
				if (initCmds < NumBeats) begin
					expAddr = initAddress(initCmds);
					if (DRAMCommandAddress !== expAddr || DRAMCommand !== DDRCmdWrite) begin
						mismatch($sformatf("init beat %0d command %0d address %h, expected %0d %h",
							initCmds, DRAMCommand, DRAMCommandAddress, DDRCmdWrite, expAddr));
					end
					initCmds++;
				end else if (!pathActive) begin
					failure("DRAM command issued with no path pending");
				end else begin
					expAddr = pathAddress(pathLeaf, pathBeats);
					expCmd = pathWrite ? DDRCmdWrite : DDRCmdRead;
					if (DRAMCommandAddress !== expAddr || DRAMCommand !== expCmd) begin
						mismatch($sformatf("path %0d beat %0d command %0d address %h, expected %0d %h",
							pathNumber, pathBeats, DRAMCommand, DRAMCommandAddress, expCmd, expAddr));
					end
					pathBeats++;
					if (pathBeats == (ORAML + 1) * BucketBeats) begin
						// Leaf end of the path against the data file
						if (DRAMCommandAddress !== pathLast) begin
							mismatch($sformatf("path %0d last address %h, data file gives %h",
								pathNumber, DRAMCommandAddress, pathLast));
						end
						finishTest($sformatf("path %0d, %s leaf %0d", pathNumber,
							pathWrite ? "write" : "read", pathLeaf), pathStartErrors);
						pathActive = 1'b0;
					end
				end
			end
			// New frontend request
			if (CommandValid && CommandReady) begin
				if (pathActive) begin
					failure("Frontend command accepted while a path was running");
				end
				pathActive = 1'b1;
				pathBeats = 0;
				pathNumber++;
				pathStartErrors = errorCount;
				pathLeaf = int'(CurrentLeaf);
				pathWrite = Command;
				pathLast = expectedLast;
			end
			if (!initFinished && initCmds == NumBeats && initData == NumBeats) begin
				initFinished = 1'b1;
				finishTest("init, 45 beats", 0);
			end
		end
	end

endmodule

/* backend_properties.sv */
// --------------------------------------------------------------------------
// Handshake assertions for the backend DRAM channels, bound to the top
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module backendProperties import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic initMode,
	input logic [DDRAWidth-1:0] DRAMCommandAddress,
	input logic [DDRCWidth-1:0] DRAMCommand,
	input logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [DDRDWidth-1:0] DRAMWriteData,
	input logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady
);

	// Read by the testbench top
	int failCount = 0;

	// Stalled command keeps valid, code and address
	cmdHold: assert property (@(posedge Clock) disable iff (!rstN)
		DRAMCommandValid && !DRAMCommandReady |=>
		DRAMCommandValid && $stable(DRAMCommand) && $stable(DRAMCommandAddress))
	else begin
		$error("DRAM command changed while stalled");
		failCount = failCount + 1;
	end

	// Stalled data word stays put
	dataHold: assert property (@(posedge Clock) disable iff (!rstN)
		DRAMWriteDataValid && !DRAMWriteDataReady |=>
		DRAMWriteDataValid && $stable(DRAMWriteData))
	else begin
		$error("DRAM write data changed while stalled");
		failCount = failCount + 1;
	end

	noDataInNormal: assert property (@(posedge Clock) disable iff (!rstN)
		!initMode |-> !DRAMWriteDataValid)
	else begin
		$error("DRAM write data valid in normal mode");
		failCount = failCount + 1;
	end

endmodule

bind pathORAMBackend backendProperties props_i (
	.Clock(Clock),
	.rstN(rstN),
	.initMode(initMode),
	.DRAMCommandAddress(DRAMCommandAddress),
	.DRAMCommand(DRAMCommand),
	.DRAMCommandValid(DRAMCommandValid),
	.DRAMCommandReady(DRAMCommandReady),
	.DRAMWriteData(DRAMWriteData),
	.DRAMWriteDataValid(DRAMWriteDataValid),
	.DRAMWriteDataReady(DRAMWriteDataReady)
);

/* pathORAMBackend.sv */
// --------------------------------------------------------------------------
// Path ORAM backend top, mode control and DRAM command steering
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module pathORAMBackend import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	// Frontend
	input logic CommandValid,
	input logic Command,
	input logic [ORAML-1:0] CurrentLeaf,
	output logic CommandReady,
	// DRAM commands
	output logic [DDRAWidth-1:0] DRAMCommandAddress,
	output logic [DDRCWidth-1:0] DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	// DRAM write data
	output logic [DDRDWidth-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady
);

	logic initMode;
	logic initDone;

	// Initializer side
	logic [DDRAWidth-1:0] initAddress;
	logic [DDRCWidth-1:0] initCommand;
	logic initCommandValid;
	logic initCommandReady;
	logic [DDRDWidth-1:0] initWriteData;
	logic initWriteDataValid;
	logic initWriteDataReady;

	// Address generator side
	logic [DDRAWidth-1:0] genAddress;
	logic [DDRCWidth-1:0] genCommand;
	logic genCommandValid;
	logic genCommandReady;
	logic genIdle;

	// ----------------------------------------------------------------------
	// Mode selection
	// ----------------------------------------------------------------------

	assign DRAMCommandAddress = initMode ? initAddress : genAddress;
	assign DRAMCommand = initMode ? initCommand : genCommand;
	assign DRAMCommandValid = initMode ? initCommandValid : genCommandValid;

	// Readies only reach the current owner
	assign initCommandReady = DRAMCommandReady & initMode;
	assign initWriteDataReady = DRAMWriteDataReady & initMode;
	assign genCommandReady = DRAMCommandReady & ~initMode;

	// Write data only ever comes from the initializer
	assign DRAMWriteData = initWriteData;
	assign DRAMWriteDataValid = initWriteDataValid;

	assign CommandReady = genIdle & ~initMode;

	backendControl control (
		.Clock(Clock),
		.rstN(rstN),
		.initDone(initDone),
		.initMode(initMode)
	);

	dramInitializer initializer (
		.Clock(Clock),
		.rstN(rstN),
		.DRAMCommandAddress(initAddress),
		.DRAMCommand(initCommand),
		.DRAMCommandValid(initCommandValid),
		.DRAMCommandReady(initCommandReady),
		.DRAMWriteData(initWriteData),
		.DRAMWriteDataValid(initWriteDataValid),
		.DRAMWriteDataReady(initWriteDataReady),
		.initDone(initDone)
	);

	pathAddrGen addrGen (
		.Clock(Clock),
		.rstN(rstN),
		.enable(~initMode),
		.start(CommandValid),
		.isWrite(Command),
		.leaf(CurrentLeaf),
		.idle(genIdle),
		.DRAMCommandAddress(genAddress),
		.DRAMCommand(genCommand),
		.DRAMCommandValid(genCommandValid),
		.DRAMCommandReady(genCommandReady)
	);

endmodule

/* pathAddrGen.sv */
// --------------------------------------------------------------------------
// Path address generator, one DRAM command per beat from root to leaf
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module pathAddrGen import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	// Low during initialization
	input logic enable,
	input logic start,
	// 1 for a write path
	input logic isWrite,
	input logic [ORAML-1:0] leaf,
	output logic idle,
	// Command channel
	output logic [DDRAWidth-1:0] DRAMCommandAddress,
	output logic [DDRCWidth-1:0] DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady
);

	logic busy;
	logic accept;
	logic cmdFire;
	logic lastBeatOfBucket;
	logic lastLevel;
	logic [LevelWidth-1:0] level;
	logic [BeatWidth-1:0] beat;
	// Latched request
	logic [ORAML-1:0] leafReg;
	logic writeReg;
	// Heap position of the leaf, leaf plus 2^ORAML
	logic [BucketWidth-1:0] heapPos;
	logic [BucketWidth-1:0] bucket;

	// ----------------------------------------------------------------------
	// Request handshake
	// ----------------------------------------------------------------------

	assign idle = ~busy;
	assign accept = enable & start & idle;
	assign cmdFire = DRAMCommandValid & DRAMCommandReady;

	assign lastBeatOfBucket = (beat == BucketBeats - 1);
	assign lastLevel = (level == ORAML);

	// ----------------------------------------------------------------------
	// Level and beat counters
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			level <= '0;
			beat <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			level <= '0;
			beat <= '0;
		end else if (cmdFire) begin
			if (lastBeatOfBucket) begin
				beat <= '0;
				if (lastLevel) begin
					// Path finished, ready again next cycle
					busy <= 1'b0;
				end else begin
					level <= level + 1'b1;
				end
			end else begin
				beat <= beat + 1'b1;
			end
		end
	end

	// Request payload, only taken on accept
	always_ff @(posedge Clock) begin
		if (accept) begin
			leafReg <= leaf;
			writeReg <= isWrite;
		end
	end

	// ----------------------------------------------------------------------
	// Bucket and address
	// ----------------------------------------------------------------------

	assign heapPos = {1'b1, leafReg};

	// Ancestor at this level, heap order with root at 0
	assign bucket = (heapPos >> (ORAML - level)) - 1'b1;

	assign DRAMCommandValid = busy;
	assign DRAMCommand = writeReg ? DDRCmdWrite : DDRCmdRead;
	assign DRAMCommandAddress = beatAddress(bucket, beat);

endmodule

/* dramInitializer.sv */
// --------------------------------------------------------------------------
// DRAM initializer, writes a header and zero blocks into every bucket
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module dramInitializer import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	// Command channel
	output logic [DDRAWidth-1:0] DRAMCommandAddress,
	output logic [DDRCWidth-1:0] DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	// Write data channel
	output logic [DDRDWidth-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady,
	// Level, stays high once set
	output logic initDone
);

	logic [BucketWidth-1:0] bucket;
	logic [BeatWidth-1:0] beat;
	// Started the walk, low in reset
	logic running;
	// Halves of the current beat already accepted
	logic cmdSent;
	logic dataSent;
	logic cmdFire;
	logic dataFire;
	logic beatDone;
	logic lastBeatOfBucket;
	logic lastBeat;
	dramWord word;

	// ----------------------------------------------------------------------
	// Handshakes
	// ----------------------------------------------------------------------

	assign DRAMCommandValid = running & ~cmdSent;
	assign DRAMWriteDataValid = running & ~dataSent;
	assign cmdFire = DRAMCommandValid & DRAMCommandReady;
	assign dataFire = DRAMWriteDataValid & DRAMWriteDataReady;

	// Both halves in, now or earlier
	assign beatDone = running & (cmdSent | cmdFire) & (dataSent | dataFire);

	assign lastBeatOfBucket = (beat == BucketBeats - 1);
	assign lastBeat = lastBeatOfBucket & (bucket == NumBuckets - 1);

	// ----------------------------------------------------------------------
	// Walk over buckets and beats
	// ----------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			bucket <= '0;
			beat <= '0;
			running <= 1'b0;
			cmdSent <= 1'b0;
			dataSent <= 1'b0;
			initDone <= 1'b0;
		end else if (!running) begin
			// Kick off once, never again after done
			running <= ~initDone;
		end else if (beatDone) begin
			cmdSent <= 1'b0;
			dataSent <= 1'b0;
			if (lastBeat) begin
				running <= 1'b0;
				initDone <= 1'b1;
			end else if (lastBeatOfBucket) begin
				beat <= '0;
				bucket <= bucket + 1'b1;
			end else begin
				beat <= beat + 1'b1;
			end
		end else begin
			// Remember the half that went through
			cmdSent <= cmdSent | cmdFire;
			dataSent <= dataSent | dataFire;
		end
	end

	// ----------------------------------------------------------------------
	// Command and data word
	// ----------------------------------------------------------------------

	assign DRAMCommand = DDRCmdWrite;
	assign DRAMCommandAddress = beatAddress(bucket, beat);

	// Header on beat 0, empty blocks after it
	always_comb begin
		word.raw = '0;
		if (beat == '0) begin
			word.header.valid = '0;
			word.header.iv = IVWidth'(bucket);
		end
	end

	assign DRAMWriteData = word.raw;

endmodule

/* backendControl.sv */
// --------------------------------------------------------------------------
// Backend mode FSM, initialize then normal operation
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module backendControl import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	// Initializer has written every beat
	input logic initDone,
	// High while DRAM belongs to the initializer
	output logic initMode
);

	// ----------------------------------------------------------------------
	// State register
	// ----------------------------------------------------------------------

	logic state;
	logic nextState;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= StInitialize;
		end else begin
			state <= nextState;
		end
	end

	// One way only, normal mode is never left
	always_comb begin
		nextState = state;
		case (state)
			StInitialize: begin
				if (initDone) begin
					nextState = StNormal;
				end
			end
			default: begin
				nextState = StNormal;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// Arbitration choice
	// ----------------------------------------------------------------------

	// Single place the DRAM owner is decided
	assign initMode = (state == StInitialize);

endmodule

/* oramPkg.sv */
// --------------------------------------------------------------------------
// Tree geometry, DRAM widths and command codes for the ORAM backend
// DRAM word union and the shared beat address function
// --------------------------------------------------------------------------
package oramPkg;

	// ----------------------------------------------------------------------
	// Tree geometry
	// ----------------------------------------------------------------------

	// Levels below the root, also the leaf width
	localparam int ORAML = 3;
	// Blocks per bucket
	localparam int ORAMZ = 2;
	localparam int NumBuckets = (2 ** (ORAML + 1)) - 1;
	// Header beat plus one beat per block
	localparam int BucketBeats = ORAMZ + 1;
	localparam int NumBeats = NumBuckets * BucketBeats;

	// Counter widths
	localparam int BucketWidth = ORAML + 1;
	localparam int BeatWidth = $clog2(BucketBeats);
	localparam int LevelWidth = $clog2(ORAML + 1);

	// ----------------------------------------------------------------------
	// DRAM side
	// ----------------------------------------------------------------------

	localparam int BeatStride = 8;
	localparam int DDRAWidth = 16;
	localparam int DDRCWidth = 3;
	localparam int DDRDWidth = 64;
	localparam logic [DDRCWidth-1:0] DDRCmdWrite = 3'd0;
	localparam logic [DDRCWidth-1:0] DDRCmdRead = 3'd1;

	// Header layout
	localparam int IVWidth = 32;
	localparam int PadWidth = DDRDWidth - IVWidth - ORAMZ;

	// Backend mode encodings
	localparam logic StInitialize = 1'b0;
	localparam logic StNormal = 1'b1;

	// One DRAM beat, seen as payload or as bucket header
	typedef union packed {
		logic [DDRDWidth-1:0] raw;
		struct packed {
			logic [PadWidth-1:0] pad;
			logic [IVWidth-1:0] iv;
			logic [ORAMZ-1:0] valid;
		} header;
	} dramWord;

	// Beat b of bucket i sits at (i * BucketBeats + b) * BeatStride
	function automatic logic [DDRAWidth-1:0] beatAddress(
		input logic [BucketWidth-1:0] bucket,
		input logic [BeatWidth-1:0] beat
	);
		beatAddress = ((DDRAWidth'(bucket) * DDRAWidth'(BucketBeats)) + DDRAWidth'(beat))
			* DDRAWidth'(BeatStride);
	endfunction

endpackage
